/* common/lb_rd_if.sv */
`timescale 1ns/10ps
`default_nettype none

// column read port between the line buffer and the window loader
interface lb_rd_if import sr_pkg::*; ();

    logic             line_avail;  // three lines stored, not yet swept
    logic             rd_en;       // read one column of all three lines
    logic [COL_W-1:0] rd_col;      // column to read
    pix_word_t [2:0]  rd_data;     // [0] oldest line, one cycle after rd_en
    logic             line_done;   // sweep of the current line finished

    // buffer side
    modport lb_mp (
        output line_avail, rd_data,
        input  rd_en, rd_col, line_done
    );

    // loader side
    modport ld_mp (
        input  line_avail, rd_data,
        output rd_en, rd_col, line_done
    );

endinterface

`default_nettype wire

/* common/sr_pkg.sv */
`default_nettype none

// ====================
// shared widths and types for the line buffer / bit-plane datapath
// ====================

package sr_pkg;

    // pixel and word geometry
    localparam int PIX_W   = 8;               // bits per pixel
    localparam int CH_NUM  = 2;               // channels packed in one input word
    localparam int WORD_W  = PIX_W * CH_NUM;  // 16 bit memory word

    // line geometry
    localparam int MAX_W   = 16;              // widest line the banks can hold
    localparam int COL_W   = 5;               // column index / width field, holds MAX_W

    // window geometry
    localparam int WIN_N   = 9;               // 3x3 words per window
    localparam int PLANE_W = WIN_N * CH_NUM;  // one bit per pixel per plane, 18
    localparam int WIN_W   = WIN_N * WORD_W;  // full window, 144

    // one input word, seen either as the raw memory word
    // or as its channel pixels (pix[0] is the low byte)
    typedef union packed {
        logic [WORD_W-1:0]            raw;   // as stored in the banks
        logic [CH_NUM-1:0][PIX_W-1:0] pix;   // per-channel view
    } pix_word_t;

    // 3x3 neighbourhood, row major
    // index 0 = oldest line, leftmost column
    // index 8 = newest line, rightmost column
    typedef pix_word_t [WIN_N-1:0] window_t;

endpackage

`default_nettype wire

/* line_buffer/line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

// three rotating line banks, written one line at a time,
// read one column (all three lines) at a time
module line_buffer import sr_pkg::*; (
    input  wire logic             SYS_CLK,
    input  wire logic             SYS_NRST,
    input  wire pix_word_t        data_i,      // pixel word
    input  wire logic             data_vld_i,
    input  wire logic             data_sop_i,  // frame start, no beat on this cycle
    input  wire logic [COL_W-1:0] pic_w_i,     // line width, 3..MAX_W
    output logic                  wready_o,
    lb_rd_if.lb_mp                rd
);

    // ====================
    // storage and write state
    // ====================
    pix_word_t bank_mem [0:2][0:MAX_W-1];           // one bank per line

    logic [COL_W-1:0]          wr_col_q;            // next column to write
    logic [1:0]                wr_bank_q;           // bank taking the next line, 0..2
    logic [1:0]                line_cnt_q;          // stored lines, saturates at 3
    logic [$clog2(MAX_W)-1:0]  wr_addr;
    logic [$clog2(MAX_W)-1:0]  rd_addr;
    logic                      full;                // full set of three lines
    logic                      wr_beat;
    logic                      line_end;            // beat that completes a line

    // modulo-3 bank offset, keeps the rotation in 0..2
    function automatic logic [1:0] bank_add(input logic [1:0] base, input logic [1:0] ofs);
        logic [2:0] sum;
        sum = {1'b0, base} + {1'b0, ofs};
        bank_add = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
    endfunction

    assign full     = (line_cnt_q == 2'd3);
    assign wready_o = ~full;                        // writes pause while a set waits or is swept
    assign rd.line_avail = full;

    assign wr_beat  = data_vld_i & wready_o;
    assign line_end = wr_beat & (wr_col_q == pic_w_i - 1'b1);   // width taken from pic_w_i

    assign wr_addr  = wr_col_q[$clog2(MAX_W)-1:0];
    assign rd_addr  = rd.rd_col[$clog2(MAX_W)-1:0];

    // ====================
    // line / bank bookkeeping
    // ====================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            wr_col_q   <= '0;
            wr_bank_q  <= '0;
            line_cnt_q <= '0;
        end else if (data_sop_i) begin
            // new frame, forget whatever lines were kept
            wr_col_q   <= '0;
            wr_bank_q  <= '0;
            line_cnt_q <= '0;
        end else if (rd.line_done) begin
            line_cnt_q <= 2'd2;                     // oldest bank released, two newer lines kept
        end else if (wr_beat) begin
            if (line_end) begin
                wr_col_q   <= '0;                   // wrap at width
                wr_bank_q  <= bank_add(wr_bank_q, 2'd1);
                line_cnt_q <= line_cnt_q + 1'b1;    // tops out at 3, no beats once full
            end else begin
                wr_col_q   <= wr_col_q + 1'b1;
            end
        end
    end

    // ====================
    // bank write and column read
    // ====================
    always_ff @(posedge SYS_CLK) begin
        if (wr_beat) begin
            bank_mem[wr_bank_q][wr_addr] <= data_i;
        end
    end

    // once full, wr_bank_q points at the oldest line,
    // so walking up from it gives oldest-first order
    always_ff @(posedge SYS_CLK) begin
        if (rd.rd_en) begin
            for (int k = 0; k < 3; k++) begin
                rd.rd_data[k] <= bank_mem[bank_add(wr_bank_q, 2'(k))][rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the sr_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sr_top.f --top-module sr_top_tb -o sr_top_sim

out=$(./obj_dir/sr_top_sim || true)
echo "$out"
if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

/* sr_top.f */
common/sr_pkg.sv
common/lb_rd_if.sv
line_buffer/line_buffer.sv
verilog/window_loader.sv
verilog/plane_serializer.sv
verilog/sr_top.sv
tb/sr_top_tb.sv

/* tb/sr_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sr_top_tb import sr_pkg::*; ();

    // ====================
    // stimulus table
    // ====================
    localparam int N_TESTS    = 7;
    localparam int RST_CYCLES = 4;

    string test_name [0:N_TESTS-1] = '{"narrow_w3", "full_w16", "out_stall", "in_gaps",
                                       "restart_pre", "restart_new", "mixed"};
    // pic_w, lines, input gap %, output stall %
    int test_cfg [0:N_TESTS-1][0:3] = '{
        '{ 3, 3,  0,  0},      // single window
        '{16, 6,  0,  0},      // bank rotation over four swept lines
        '{ 8, 4,  0, 50},
        '{10, 4, 40,  0},
        '{ 7, 2,  0,  0},      // frame cut short, next sop drops it
        '{ 7, 3, 20, 30},
        '{12, 5, 25, 25}
    };

    logic               SYS_CLK;
    logic               SYS_NRST;
    logic [WORD_W-1:0]  data_i;
    logic               data_vld_i;
    logic               data_sop_i;
    logic [COL_W-1:0]   pic_w_i;
    logic               wready_o;
    logic [PLANE_W-1:0] opu_plane_o;
    logic               opu_vld_o;
    logic               opu_rdy_i;

    // reference model state
    logic [WORD_W-1:0]  kept [0:2][0:MAX_W-1];     // last three lines, [0] oldest
    logic [WORD_W-1:0]  new_line [0:MAX_W-1];      // line being written
    logic [PLANE_W-1:0] exp_q [$];                 // planes still owed by the DUT
    logic [PLANE_W-1:0] exp_plane;
    logic [PLANE_W-1:0] held_plane;                // value seen on a stalled cycle
    logic               held_vld;
    logic [WORD_W-1:0]  word;
    int                 col_cnt, line_cnt, plane_cnt, cur_stall;
    int                 w, n_words, gap, sent, wd_cycles;
    string              cur_name;

    sr_top i_sr_top (.*);

    initial begin
        SYS_CLK = 1'b0;
        forever #20 SYS_CLK = ~SYS_CLK;           // 40 ns period
    end

    // ====================
    // helpers
    // ====================
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // owed planes for every window of the three kept lines, column then plane
    function automatic void queue_windows(input int width);
        logic [PLANE_W-1:0] plane;
        logic [WORD_W-1:0]  wd;
        for (int c = 0; c <= width - 3; c++) begin
            for (int b = 0; b < PIX_W; b++) begin
                plane = '0;
                for (int r = 0; r < 3; r++) begin
                    for (int k = 0; k < 3; k++) begin
                        wd = kept[r][c+k];
                        for (int ch = 0; ch < CH_NUM; ch++)
                            plane[(r*3 + k)*CH_NUM + ch] = wd[ch*PIX_W + b];  // low byte = ch 0
                    end
                end
                exp_q.push_back(plane);
            end
        end
    endfunction

    function automatic void accept_word(input logic [WORD_W-1:0] wd, input int width);
        new_line[col_cnt] = wd;
        col_cnt++;
        if (col_cnt == width) begin                // line complete, age the kept lines
            col_cnt = 0;
            for (int i = 0; i < MAX_W; i++) begin
                kept[0][i] = kept[1][i];
                kept[1][i] = kept[2][i];
                kept[2][i] = new_line[i];
            end
            line_cnt++;
            if (line_cnt >= 3)
                queue_windows(width);
        end
    endfunction

    // ====================
    // output side
    // ====================
    initial begin
        forever begin
            @(posedge SYS_CLK);
            #2 opu_rdy_i = (int'($urandom % 100) >= cur_stall);
        end
    end

    always @(negedge SYS_CLK) begin
        if (held_vld) begin                        // plane must hold through a stall
            assert (opu_vld_o) else
                fail_stop($sformatf("%s: opu_vld_o dropped before its transfer", cur_name));
            assert (opu_plane_o == held_plane) else
                fail_stop($sformatf("ERR %s stalled plane: expected %05h actual %05h",
                                    cur_name, held_plane, opu_plane_o));
        end
        if (opu_vld_o && opu_rdy_i) begin
            assert (exp_q.size() > 0) else
                fail_stop($sformatf("%s: a plane came out with none expected", cur_name));
            exp_plane = exp_q.pop_front();
            assert (opu_plane_o == exp_plane) else
                fail_stop($sformatf("ERR %s plane %0d: expected %05h actual %05h",
                                    cur_name, plane_cnt, exp_plane, opu_plane_o));
            plane_cnt++;
        end
        held_vld   = opu_vld_o && !opu_rdy_i;
        held_plane = opu_plane_o;
    end

    // watchdog sized from the table
    initial begin
        n_words   = 0;
        wd_cycles = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            n_words   += test_cfg[t][0] * test_cfg[t][1];
            if (test_cfg[t][1] > 2)
                wd_cycles += 8 * (test_cfg[t][1] - 2) * (test_cfg[t][0] - 2);
        end
        wd_cycles = 4 * (n_words + wd_cycles) + RST_CYCLES + 40 * N_TESTS;
        repeat (wd_cycles) @(posedge SYS_CLK);
        fail_stop($sformatf("watchdog timeout, run not finished after %0d cycles", wd_cycles));
    end

    // ====================
    // main sequence
    // ====================
    initial begin
        void'($urandom(32'h7d5c_26f3));
        SYS_NRST   = 1'b0;
        data_i     = '0;
        data_vld_i = 1'b0;
        data_sop_i = 1'b0;
        pic_w_i    = COL_W'(3);
        opu_rdy_i  = 1'b0;
        cur_stall  = 0;
        cur_name   = "reset";
        held_vld   = 1'b0;
        plane_cnt  = 0;
        for (int i = 0; i <= RST_CYCLES; i++) begin
            @(negedge SYS_CLK);                    // last pass is just after release
            assert (!opu_vld_o && wready_o) else
                fail_stop($sformatf("ERR reset: expected vld=0 wready=1 actual vld=%0b wready=%0b",
                                    opu_vld_o, wready_o));
            if (i == RST_CYCLES - 1) begin
                @(posedge SYS_CLK);
                #2 SYS_NRST = 1'b1;
            end
        end

        for (int t = 0; t < N_TESTS; t++) begin
            cur_name  = test_name[t];
            w         = test_cfg[t][0];
            gap       = test_cfg[t][2];
            cur_stall = test_cfg[t][3];
            col_cnt   = 0;                         // sop restarts the model too
            line_cnt  = 0;
            plane_cnt = 0;
            @(posedge SYS_CLK);
            #2;
            pic_w_i    = COL_W'(w);
            data_sop_i = 1'b1;
            data_vld_i = 1'b0;
            @(posedge SYS_CLK);
            #2 data_sop_i = 1'b0;
            for (int n = 0; n < w * test_cfg[t][1]; n++) begin
                word = WORD_W'($urandom);
                sent = 0;
                while (sent == 0) begin
                    if (int'($urandom % 100) < gap) begin
                        data_vld_i = 1'b0;         // idle cycle
                    end else begin
                        data_vld_i = 1'b1;
                        data_i     = word;
                    end
                    @(negedge SYS_CLK);
                    if (data_vld_i && wready_o) begin   // only real beats reach the model
                        accept_word(word, w);
                        sent = 1;
                    end
                    @(posedge SYS_CLK);
                    #2;
                end
            end
            data_vld_i = 1'b0;
            while (exp_q.size() != 0) @(negedge SYS_CLK);
            // last line_done has released the oldest bank, writes open again
            assert (wready_o) else
                fail_stop($sformatf("ERR %s wready after drain: expected 1 actual %0b",
                                    cur_name, wready_o));
        end

        repeat (20) @(negedge SYS_CLK);            // nothing stray after the last row
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_stop($sformatf("%0d planes still queued at the end", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

/* verilog/plane_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

// holds one window and hands it out as PIX_W bit planes, LSB first
module plane_serializer import sr_pkg::*; (
    input  wire logic               SYS_CLK,
    input  wire logic               SYS_NRST,
    input  wire window_t            win_i,
    input  wire logic               win_vld_i,
    output logic                    win_rdy_o,
    output logic [PLANE_W-1:0]      opu_plane_o,  // bit (word*CH_NUM + ch) of current plane
    output logic                    opu_vld_o,
    input  wire logic               opu_rdy_i
);

    logic [WIN_W-1:0]           hold_q;     // stored window bits
    window_t                    hold_win;   // word / channel view of hold_q
    logic                       full_q;
    logic [$clog2(PIX_W)-1:0]   plane_q;    // current bit plane
    logic                       take;
    logic                       xfer;

    assign take      = win_vld_i & ~full_q;  // only an empty holder takes a window
    assign xfer      = full_q & opu_rdy_i;
    assign win_rdy_o = ~full_q;
    assign opu_vld_o = full_q;
    assign hold_win  = hold_q;

    // ====================
    // plane sequencing
    // ====================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            full_q  <= 1'b0;
            plane_q <= '0;
        end else if (take) begin
            full_q  <= 1'b1;                  // plane 0 shows next cycle
            plane_q <= '0;
        end else if (xfer) begin
            plane_q <= plane_q + 1'b1;
            if (plane_q == $clog2(PIX_W)'(PIX_W-1))
                full_q <= 1'b0;               // last plane gone, free the holder
        end
    end

    always_ff @(posedge SYS_CLK) begin
        if (take)
            hold_q <= win_i;
    end

    // pick bit plane_q of every channel pixel
    always_comb begin
        for (int w = 0; w < WIN_N; w++) begin
            for (int c = 0; c < CH_NUM; c++) begin
                opu_plane_o[w*CH_NUM + c] = hold_win[w].pix[c][plane_q];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sr_top.sv */
`timescale 1ns/10ps
`default_nettype none

// line buffer -> window loader -> bit-plane serializer
module sr_top import sr_pkg::*; (
    input  wire logic               SYS_CLK,
    input  wire logic               SYS_NRST,

    // pixel input, one line at a time
    input  wire logic [WORD_W-1:0]  data_i,
    input  wire logic               data_vld_i,
    output logic                    wready_o,
    input  wire logic               data_sop_i,
    input  wire logic [COL_W-1:0]   pic_w_i,

    // bit-plane output to the compute unit
    output logic [PLANE_W-1:0]      opu_plane_o,
    output logic                    opu_vld_o,
    input  wire logic               opu_rdy_i
);

    // ====================
    // internal links
    // ====================
    lb_rd_if u_lb_rd_if ();           // column reads

    logic    win_vld;                 // loader -> serializer handshake
    logic    win_rdy;
    window_t win;

    // ====================
    // instances
    // ====================
    line_buffer u_line_buffer (
        .SYS_CLK     (SYS_CLK),
        .SYS_NRST    (SYS_NRST),
        .data_i      (data_i),        // raw word into the union port
        .data_vld_i  (data_vld_i),
        .data_sop_i  (data_sop_i),
        .pic_w_i     (pic_w_i),
        .wready_o    (wready_o),
        .rd          (u_lb_rd_if.lb_mp)
    );

    window_loader u_window_loader (
        .SYS_CLK     (SYS_CLK),
        .SYS_NRST    (SYS_NRST),
        .rd          (u_lb_rd_if.ld_mp),
        .pic_w_i     (pic_w_i),
        .win_vld_o   (win_vld),
        .win_rdy_i   (win_rdy),
        .win_o       (win)
    );

    plane_serializer u_plane_serializer (
        .SYS_CLK     (SYS_CLK),
        .SYS_NRST    (SYS_NRST),
        .win_i       (win),
        .win_vld_i   (win_vld),
        .win_rdy_o   (win_rdy),
        .opu_plane_o (opu_plane_o),
        .opu_vld_o   (opu_vld_o),
        .opu_rdy_i   (opu_rdy_i)
    );

endmodule

`default_nettype wire

/* verilog/window_loader.sv */
`timescale 1ns/10ps
`default_nettype none

// sweeps the three stored lines column by column and
// presents each 3x3 neighbourhood on a valid/ready port
module window_loader import sr_pkg::*; (
    input  wire logic             SYS_CLK,
    input  wire logic             SYS_NRST,
    lb_rd_if.ld_mp                rd,
    input  wire logic [COL_W-1:0] pic_w_i,     // line width
    output logic                  win_vld_o,
    input  wire logic             win_rdy_i,
    output window_t               win_o
);

    // ====================
    // state
    // ====================
    logic [COL_W-1:0] rd_col_q;        // next column to read
    logic [COL_W-1:0] rcv_cnt_q;       // columns shifted into the window
    logic             rd_vld_q;        // rd_data carries a column this cycle
    logic             win_vld_q;

    pix_word_t [2:0]  skid_q;          // one parked column under back-pressure
    logic             skid_vld_q;
    pix_word_t [2:0]  col_q [0:2];     // [0] leftmost column, [2] newest

    logic             stall;           // window offered but not taken
    logic             shift_en;
    logic             line_last;       // last window of the line transfers
    pix_word_t [2:0]  shift_data;

    assign stall      = win_vld_q & ~win_rdy_i;
    assign shift_en   = ~stall & (skid_vld_q | rd_vld_q);
    assign shift_data = skid_vld_q ? skid_q : rd.rd_data;   // parked column goes first
    assign line_last  = win_vld_q & win_rdy_i & (rcv_cnt_q == pic_w_i);

    // one read per cycle until the line is covered, held off while stalled
    assign rd.rd_en     = rd.line_avail & (rd_col_q < pic_w_i) & ~stall;
    assign rd.rd_col    = rd_col_q;
    assign rd.line_done = line_last;

    assign win_vld_o = win_vld_q;

    // ====================
    // control
    // ====================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            rd_col_q   <= '0;
            rcv_cnt_q  <= '0;
            rd_vld_q   <= 1'b0;
            win_vld_q  <= 1'b0;
            skid_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= rd.rd_en;                   // buffer answers one cycle later
            if (line_last) begin
                rd_col_q  <= '0;                    // ready for the next line
                rcv_cnt_q <= '0;
                win_vld_q <= 1'b0;
            end else begin
                if (rd.rd_en)
                    rd_col_q <= rd_col_q + 1'b1;
                if (shift_en) begin
                    rcv_cnt_q <= rcv_cnt_q + 1'b1;
                    win_vld_q <= (rcv_cnt_q >= COL_W'(2));   // third column onwards
                end else if (win_rdy_i) begin
                    win_vld_q <= 1'b0;              // consumed, nothing new behind it
                end
            end
            // a read already in flight when the stall hit lands here
            if (rd_vld_q & stall)
                skid_vld_q <= 1'b1;
            else if (~stall)
                skid_vld_q <= 1'b0;
        end
    end

    // ====================
    // column shift register
    // ====================
    always_ff @(posedge SYS_CLK) begin
        if (rd_vld_q & stall)
            skid_q <= rd.rd_data;
        if (shift_en) begin
            col_q[0] <= col_q[1];
            col_q[1] <= col_q[2];
            col_q[2] <= shift_data;
        end
    end

    // row major window, row 0 = oldest line
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                win_o[r*3 + c] = col_q[c][r];
            end
        end
    end

endmodule

`default_nettype wire
